/* verilog/shared_mem_settings.svh */
/*
  Memory geometry and forwarding mode for the shared memory block.
  SHARED_MEM_ADDR_WIDTH must be the base-2 log of SHARED_MEM_DEPTH.
*/
`ifndef SHARED_MEM_SETTINGS_SVH
`define SHARED_MEM_SETTINGS_SVH

// Bits per memory word
`define SHARED_MEM_WIDTH 8

// Number of words in the array
`define SHARED_MEM_DEPTH 16

// Address bits, sized to cover the depth exactly
`define SHARED_MEM_ADDR_WIDTH 4

// Read forwarding mode
// 1 forwards same-cycle write data to the reading port
// 0 returns the array contents from before the write
`define SHARED_MEM_WRITE_THROUGH 1

`endif

/* verilog/shared_mem_pkg.sv */
/*
  Types shared by the RAM, the port sequencers and the top level.
  Widths come from the settings header.
*/
`include "shared_mem_settings.svh"

package shared_mem_pkg;

  // One word address into the array
  typedef logic [`SHARED_MEM_ADDR_WIDTH-1:0] addr_t;

  // One memory word
  typedef logic [`SHARED_MEM_WIDTH-1:0] data_t;

  // Sequencer phases for one handshake
  // seq_idle     waiting for req
  // seq_access   RAM enable pulse on the bus
  // seq_capture  RAM read register settling
  // seq_hold     ack high until req drops
  typedef enum logic [1:0] {
    seq_idle    = 2'd0,
    seq_access  = 2'd1,
    seq_capture = 2'd2,
    seq_hold    = 2'd3
  } seq_state_t;

endpackage

/* verilog/true_dual_port_ram.sv */
/*
  Two read-write ports, synchronous writes, one cycle of read latency.
  Same-address writes in one cycle leave port 1's data in the array.
*/
`timescale 1ns/100ps

`include "shared_mem_settings.svh"

module true_dual_port_ram (
  input  logic                  clock,
  // Port 0
  input  logic                  port_0_access_enable,
  input  logic                  port_0_write,
  input  shared_mem_pkg::addr_t port_0_address,
  input  shared_mem_pkg::data_t port_0_write_data,
  output shared_mem_pkg::data_t port_0_read_data,
  // Port 1
  input  logic                  port_1_access_enable,
  input  logic                  port_1_write,
  input  shared_mem_pkg::addr_t port_1_address,
  input  shared_mem_pkg::data_t port_1_write_data,
  output shared_mem_pkg::data_t port_1_read_data
);

  import shared_mem_pkg::*;

  localparam bit write_through = `SHARED_MEM_WRITE_THROUGH;

  // Storage array
  data_t memory [`SHARED_MEM_DEPTH];

  // Per-port write strobes
  logic port_0_write_enable;
  logic port_1_write_enable;

  // Both ports pointing at one word
  logic same_address;

  // Read registers, one per port
  data_t port_0_read_register;
  data_t port_1_read_register;

  assign port_0_write_enable = port_0_access_enable & port_0_write;
  assign port_1_write_enable = port_1_access_enable & port_1_write;
  assign same_address        = port_0_address == port_1_address;

  // Next read register value for one port
  // Own write comes first, then the other port's write at the same word
  function automatic data_t read_select(
    input logic  own_write,
    input data_t own_write_data,
    input logic  other_write_enable,
    input data_t other_write_data,
    input logic  address_match,
    input data_t array_word
  );
    data_t result;
    result = array_word;
    if (write_through) begin
      if (own_write) begin
        result = own_write_data;
      end else if (other_write_enable && address_match) begin
        result = other_write_data;
      end
    end
    return result;
  endfunction

  // Array update
  // Port 1 assigned last, so it wins a same-address collision
  always_ff @(posedge clock) begin
    if (port_0_write_enable) begin
      memory[port_0_address] <= port_0_write_data;
    end
    if (port_1_write_enable) begin
      memory[port_1_address] <= port_1_write_data;
    end
  end

  // Port 0 read register, loaded on any enabled access
  always_ff @(posedge clock) begin
    if (port_0_access_enable) begin
      port_0_read_register <= read_select(port_0_write, port_0_write_data,
                                          port_1_write_enable, port_1_write_data,
                                          same_address, memory[port_0_address]);
    end
  end

  // Port 1 read register, same rules mirrored
  always_ff @(posedge clock) begin
    if (port_1_access_enable) begin
      port_1_read_register <= read_select(port_1_write, port_1_write_data,
                                          port_0_write_enable, port_0_write_data,
                                          same_address, memory[port_1_address]);
    end
  end

  // Registered outputs, latency of one edge
  assign port_0_read_data = port_0_read_register;
  assign port_1_read_data = port_1_read_register;

endmodule

/* verilog/port_sequencer.sv */
/*
  Four-phase req/ack front end for one RAM port, ack three edges after req.
  Agent must keep req high until ack, and raise it again only after ack is low.
*/
`timescale 1ns/100ps

module port_sequencer (
  input  logic                  clock,
  input  logic                  rst_n,
  // Agent side handshake
  input  logic                  req,
  input  logic                  write,
  input  shared_mem_pkg::addr_t addr,
  input  shared_mem_pkg::data_t wdata,
  output logic                  ack,
  output shared_mem_pkg::data_t rdata,
  // RAM side
  output logic                  access_enable,
  output logic                  mem_write,
  output shared_mem_pkg::addr_t mem_address,
  output shared_mem_pkg::data_t mem_write_data,
  input  shared_mem_pkg::data_t mem_read_data
);

  import shared_mem_pkg::*;

  // Handshake phase
  seq_state_t state;
  seq_state_t next_state;

  // Request accepted this cycle
  logic start;

  // Latched request, held for the whole access
  logic  req_write;
  addr_t req_addr;
  data_t req_wdata;

  // Read result returned to the agent
  data_t rdata_register;

  assign start = (state == seq_idle) && req;

  // Phase sequence
  always_comb begin
    next_state = state;
    case (state)
      seq_idle: begin
        if (req) begin
          next_state = seq_access;
        end
      end
      // Single cycle of RAM enable
      seq_access: begin
        next_state = seq_capture;
      end
      // RAM read register valid at the next edge
      seq_capture: begin
        next_state = seq_hold;
      end
      // Back-pressure, stay here while req is high
      seq_hold: begin
        if (!req) begin
          next_state = seq_idle;
        end
      end
      default: begin
        next_state = seq_idle;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state <= seq_idle;
    end else begin
      state <= next_state;
    end
  end

  // Capture agent signals on leaving idle
  // Agent inputs are free to move after this edge
  always_ff @(posedge clock) begin
    if (start) begin
      req_write <= write;
      req_addr  <= addr;
      req_wdata <= wdata;
    end
  end

  // Load RAM result as ack rises, then hold it through back-pressure
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      rdata_register <= '0;
    end else if (state == seq_capture) begin
      rdata_register <= mem_read_data;
    end
  end

  // RAM bus, enable decoded from state so it pulses once
  assign access_enable  = state == seq_access;
  assign mem_write      = req_write;
  assign mem_address    = req_addr;
  assign mem_write_data = req_wdata;

  // Agent outputs
  assign ack   = state == seq_hold;
  assign rdata = rdata_register;

endmodule

/* verilog/shared_mem_top.sv */
/*
  Shared memory with two independent four-phase agent ports.
  No arbitration; same-address writes in one cycle keep port 1's data.
*/
`timescale 1ns/100ps

module shared_mem_top (
  input  logic                  clock,
  input  logic                  rst_n,
  // Agent port 0
  input  logic                  port_0_req,
  input  logic                  port_0_write,
  input  shared_mem_pkg::addr_t port_0_addr,
  input  shared_mem_pkg::data_t port_0_wdata,
  output logic                  port_0_ack,
  output shared_mem_pkg::data_t port_0_rdata,
  // Agent port 1
  input  logic                  port_1_req,
  input  logic                  port_1_write,
  input  shared_mem_pkg::addr_t port_1_addr,
  input  shared_mem_pkg::data_t port_1_wdata,
  output logic                  port_1_ack,
  output shared_mem_pkg::data_t port_1_rdata
);

  import shared_mem_pkg::*;

  // Sequencer 0 to RAM port 0
  logic  seq0_access_enable;
  logic  seq0_write;
  addr_t seq0_address;
  data_t seq0_write_data;
  data_t seq0_read_data;

  // Sequencer 1 to RAM port 1
  logic  seq1_access_enable;
  logic  seq1_write;
  addr_t seq1_address;
  data_t seq1_write_data;
  data_t seq1_read_data;

  port_sequencer seq0 (
    .clock          (clock),
    .rst_n          (rst_n),
    .req            (port_0_req),
    .write          (port_0_write),
    .addr           (port_0_addr),
    .wdata          (port_0_wdata),
    .ack            (port_0_ack),
    .rdata          (port_0_rdata),
    .access_enable  (seq0_access_enable),
    .mem_write      (seq0_write),
    .mem_address    (seq0_address),
    .mem_write_data (seq0_write_data),
    .mem_read_data  (seq0_read_data)
  );

  port_sequencer seq1 (
    .clock          (clock),
    .rst_n          (rst_n),
    .req            (port_1_req),
    .write          (port_1_write),
    .addr           (port_1_addr),
    .wdata          (port_1_wdata),
    .ack            (port_1_ack),
    .rdata          (port_1_rdata),
    .access_enable  (seq1_access_enable),
    .mem_write      (seq1_write),
    .mem_address    (seq1_address),
    .mem_write_data (seq1_write_data),
    .mem_read_data  (seq1_read_data)
  );

  // Port 1 of the RAM wins same-address write collisions
  true_dual_port_ram ram0 (
    .clock                (clock),
    .port_0_access_enable (seq0_access_enable),
    .port_0_write         (seq0_write),
    .port_0_address       (seq0_address),
    .port_0_write_data    (seq0_write_data),
    .port_0_read_data     (seq0_read_data),
    .port_1_access_enable (seq1_access_enable),
    .port_1_write         (seq1_write),
    .port_1_address       (seq1_address),
    .port_1_write_data    (seq1_write_data),
    .port_1_read_data     (seq1_read_data)
  );

endmodule

/* test/port_sequencer_asserts.sv */
/*
  Handshake checks for one port_sequencer, bound into every instance.
  Sampled on the rising clock; reset is synchronous and active low.
*/
`timescale 1ns/100ps

module port_sequencer_asserts (
  input logic clock,
  input logic rst_n,
  input logic req,
  input logic ack,
  input logic access_enable
);

  // Ack only answers a request still pending at the edge it rose
  ack_needs_req: assert property (
    @(posedge clock) disable iff (!rst_n)
    $rose(ack) |-> $past(req)
  ) else $error("ack rose while req was low");

  // RAM enable is a single cycle pulse
  enable_one_cycle: assert property (
    @(posedge clock) disable iff (!rst_n)
    access_enable |=> !access_enable
  ) else $error("access_enable stayed high for more than one cycle");

  // No new RAM access while the agent still holds ack
  no_enable_during_ack: assert property (
    @(posedge clock) disable iff (!rst_n)
    !(access_enable && ack)
  ) else $error("access_enable high while ack is high");

  // Reset edge clears the handshake
  ack_low_in_reset: assert property (
    @(posedge clock)
    !rst_n |=> !ack
  ) else $error("ack high after a reset edge");

endmodule

bind port_sequencer port_sequencer_asserts protocol_checks (
  .clock         (clock),
  .rst_n         (rst_n),
  .req           (req),
  .ack           (ack),
  .access_enable (access_enable)
);

/* test/shared_mem_tb.sv */
/*
  Directed and random tests of shared_mem_top against a word model.
  Stops at the first failure; reads only words written earlier in the run.
*/
`timescale 1ns/100ps

`include "shared_mem_settings.svh"

module shared_mem_tb;

  import shared_mem_pkg::*;

  // Twice about 280 accesses of 5 cycles plus the 20 cycle hold and reset
  localparam int timeout_cycles = 3000;
  localparam bit forwarding = `SHARED_MEM_WRITE_THROUGH;

  logic  clock;
  logic  rst_n;
  logic  port_0_req;
  logic  port_0_write;
  addr_t port_0_addr;
  data_t port_0_wdata;
  logic  port_0_ack;
  data_t port_0_rdata;
  logic  port_1_req;
  logic  port_1_write;
  addr_t port_1_addr;
  data_t port_1_wdata;
  logic  port_1_ack;
  data_t port_1_rdata;

  // Expected memory contents
  data_t model [`SHARED_MEM_DEPTH];
  int    cycle_count = 0;
  int    check_count = 0;

  shared_mem_top dut0 (
    .clock        (clock),
    .rst_n        (rst_n),
    .port_0_req   (port_0_req),
    .port_0_write (port_0_write),
    .port_0_addr  (port_0_addr),
    .port_0_wdata (port_0_wdata),
    .port_0_ack   (port_0_ack),
    .port_0_rdata (port_0_rdata),
    .port_1_req   (port_1_req),
    .port_1_write (port_1_write),
    .port_1_addr  (port_1_addr),
    .port_1_wdata (port_1_wdata),
    .port_1_ack   (port_1_ack),
    .port_1_rdata (port_1_rdata)
  );

  // 4 ns period
  always #2 clock = ~clock;

  // Run limit
  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
      stop_on_failure();
    end
  end

  task automatic stop_on_failure();
    $display("** FAIL **");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic compare_data(input string name, input data_t expected, input data_t actual);
    check_count++;
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      stop_on_failure();
    end
  endtask

  task automatic compare_bit(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
      stop_on_failure();
    end
  endtask

  function automatic logic ack_of(input int port);
    return (port == 0) ? port_0_ack : port_1_ack;
  endfunction

  function automatic data_t rdata_of(input int port);
    return (port == 0) ? port_0_rdata : port_1_rdata;
  endfunction

  // Word pattern distinct for every address
  function automatic data_t fill_word(input addr_t a, input int salt);
    return data_t'(int'(a) * 29 + salt);
  endfunction

  // Caller sits on a falling edge
  task automatic start_request(input int port, input logic wr, input addr_t a, input data_t d);
    if (port == 0) begin
      port_0_req   = 1'b1;
      port_0_write = wr;
      port_0_addr  = a;
      port_0_wdata = d;
    end else begin
      port_1_req   = 1'b1;
      port_1_write = wr;
      port_1_addr  = a;
      port_1_wdata = d;
    end
  endtask

  task automatic end_request(input int port);
    if (port == 0) begin
      port_0_req   = 1'b0;
      port_0_write = 1'b0;
    end else begin
      port_1_req   = 1'b0;
      port_1_write = 1'b0;
    end
  endtask

  // Ack due on the third falling edge after req
  task automatic await_ack(input int port, input string name);
    int waited;
    waited = 0;
    while (!ack_of(port)) begin
      if (waited == 3) begin
        $display("%s: port %0d gave no ack within 3 edges, handshake failure", name, port);
        stop_on_failure();
      end else begin
        @(negedge clock);
        waited++;
      end
    end
  endtask

  // One edge after req fell
  task automatic check_released(input int port, input string name);
    if (ack_of(port)) begin
      $display("%s: port %0d kept ack high after req fell, handshake failure", name, port);
      stop_on_failure();
    end
  endtask

  task automatic single_access(input int port, input logic wr, input addr_t a, input data_t d,
                               input string name, output data_t rd);
    @(negedge clock);
    start_request(port, wr, a, d);
    await_ack(port, name);
    rd = rdata_of(port);
    end_request(port);
    @(negedge clock);
    check_released(port, name);
  endtask

  // Both requests first sampled at the same edge
  task automatic paired_access(input logic wr0, input addr_t a0, input data_t d0,
                               input logic wr1, input addr_t a1, input data_t d1,
                               input string name, output data_t rd0, output data_t rd1);
    @(negedge clock);
    start_request(0, wr0, a0, d0);
    start_request(1, wr1, a1, d1);
    await_ack(0, name);
    await_ack(1, name);
    rd0 = rdata_of(0);
    rd1 = rdata_of(1);
    end_request(0);
    end_request(1);
    @(negedge clock);
    check_released(0, name);
    check_released(1, name);
  endtask

  // Own write comes back as rdata and a read returns the stored word
  function automatic data_t expected_single(input logic wr, input addr_t a, input data_t d);
    data_t result;
    if (wr && forwarding) begin
      result = d;
    end else begin
      result = model[a];
    end
    return result;
  endfunction

  task automatic checked_access(input int port, input logic wr, input addr_t a, input data_t d,
                                input string name);
    data_t expected;
    data_t actual;
    expected = expected_single(wr, a, d);
    single_access(port, wr, a, d, name, actual);
    compare_data(name, expected, actual);
    if (wr) begin
      model[a] = d;
    end
  endtask

  task automatic checked_pair(input logic wr0, input addr_t a0, input data_t d0,
                              input logic wr1, input addr_t a1, input data_t d1,
                              input string name, output data_t rd0, output data_t rd1);
    data_t expected_0;
    data_t expected_1;
    expected_0 = expected_single(wr0, a0, d0);
    expected_1 = expected_single(wr1, a1, d1);
    // Read meets the other port's write to the same word
    if (forwarding && !wr0 && wr1 && a0 == a1) begin
      expected_0 = d1;
    end
    if (forwarding && !wr1 && wr0 && a0 == a1) begin
      expected_1 = d0;
    end
    paired_access(wr0, a0, d0, wr1, a1, d1, name, rd0, rd1);
    compare_data({name, " port 0"}, expected_0, rd0);
    compare_data({name, " port 1"}, expected_1, rd1);
    // Port 1 applied last so it wins a same-word collision
    if (wr0) begin
      model[a0] = d0;
    end
    if (wr1) begin
      model[a1] = d1;
    end
  endtask

  task automatic reset_and_round_trip();
    compare_bit("reset port 0 ack", 1'b0, port_0_ack);
    compare_bit("reset port 1 ack", 1'b0, port_1_ack);
    compare_data("reset port 0 rdata", '0, port_0_rdata);
    compare_data("reset port 1 rdata", '0, port_1_rdata);
    checked_access(0, 1'b1, addr_t'(3), data_t'(8'h5a), "round trip port 0 write");
    checked_access(0, 1'b0, addr_t'(3), '0, "round trip port 0 read");
    checked_access(1, 1'b1, addr_t'(12), data_t'(8'hc3), "round trip port 1 write");
    checked_access(1, 1'b0, addr_t'(12), '0, "round trip port 1 read");
  endtask

  task automatic cross_port_visibility();
    // Port 0 writes, port 1 reads
    for (int i = 0; i < `SHARED_MEM_DEPTH; i++) begin
      checked_access(0, 1'b1, addr_t'(i), fill_word(addr_t'(i), 11),
                     $sformatf("cross port write 0 addr %0d", i));
    end
    for (int i = 0; i < `SHARED_MEM_DEPTH; i++) begin
      checked_access(1, 1'b0, addr_t'(i), '0, $sformatf("cross port read 1 addr %0d", i));
    end
    // And the reverse
    for (int i = 0; i < `SHARED_MEM_DEPTH; i++) begin
      checked_access(1, 1'b1, addr_t'(i), fill_word(addr_t'(i), 170),
                     $sformatf("cross port write 1 addr %0d", i));
    end
    for (int i = 0; i < `SHARED_MEM_DEPTH; i++) begin
      checked_access(0, 1'b0, addr_t'(i), '0, $sformatf("cross port read 0 addr %0d", i));
    end
  endtask

  task automatic read_during_write();
    data_t rd0;
    data_t rd1;
    data_t old_word;
    checked_pair(1'b0, addr_t'(5), '0, 1'b1, addr_t'(5), data_t'(8'ha7),
                 "read during write same word", rd0, rd1);
    if (forwarding) begin
      compare_data("read during write new data", data_t'(8'ha7), rd0);
    end
    // Port 0 sees the stored value of a different word
    old_word = model[6];
    checked_pair(1'b0, addr_t'(6), '0, 1'b1, addr_t'(7), data_t'(8'h3c),
                 "read during write other word", rd0, rd1);
    compare_data("read during write old data", old_word, rd0);
    // Mirrored roles
    checked_pair(1'b1, addr_t'(9), data_t'(8'h96), 1'b0, addr_t'(9), '0,
                 "read during write mirrored", rd0, rd1);
  endtask

  task automatic write_collision();
    data_t rd0;
    data_t rd1;
    checked_pair(1'b1, addr_t'(10), data_t'(8'h11), 1'b1, addr_t'(10), data_t'(8'h22),
                 "write collision", rd0, rd1);
    single_access(0, 1'b0, addr_t'(10), '0, "collision read port 0", rd0);
    compare_data("collision read port 0", data_t'(8'h22), rd0);
    single_access(1, 1'b0, addr_t'(10), '0, "collision read port 1", rd1);
    compare_data("collision read port 1", data_t'(8'h22), rd1);
  endtask

  task automatic back_pressure();
    data_t held_expected;
    data_t held;
    held_expected = model[2];
    fork
      // Port 0 holds req for 20 cycles after ack
      begin
        @(negedge clock);
        start_request(0, 1'b0, addr_t'(2), '0);
        await_ack(0, "back-pressure port 0");
        held = port_0_rdata;
        compare_data("back-pressure port 0 read", held_expected, held);
        repeat (20) begin
          @(negedge clock);
          compare_bit("back-pressure port 0 ack held", 1'b1, port_0_ack);
          compare_data("back-pressure port 0 rdata held", held_expected, port_0_rdata);
        end
        end_request(0);
        @(negedge clock);
        check_released(0, "back-pressure port 0");
      end
      // Port 1 keeps working and rewrites the held word
      begin
        wait (port_0_ack);
        checked_access(1, 1'b1, addr_t'(2), ~held_expected, "back-pressure port 1 write");
        checked_access(1, 1'b0, addr_t'(2), '0, "back-pressure port 1 read");
        checked_access(1, 1'b1, addr_t'(11), data_t'(8'h4e), "back-pressure port 1 other");
      end
    join
  endtask

  task automatic random_traffic();
    int    done;
    int    kind;
    logic  wr0;
    logic  wr1;
    addr_t a0;
    addr_t a1;
    data_t d0;
    data_t d1;
    data_t rd0;
    data_t rd1;
    done = 0;
    while (done < 200) begin
      // 0 and 1 pick a single port and 2 runs both
      kind = $urandom_range(0, 2);
      wr0  = $urandom_range(0, 1) == 1;
      wr1  = $urandom_range(0, 1) == 1;
      a0   = addr_t'($urandom_range(0, `SHARED_MEM_DEPTH - 1));
      a1   = addr_t'($urandom_range(0, `SHARED_MEM_DEPTH - 1));
      d0   = data_t'($urandom);
      d1   = data_t'($urandom);
      if (kind == 2) begin
        // Half of the pairs share a word
        if ($urandom_range(0, 1) == 1) begin
          a1 = a0;
        end
        checked_pair(wr0, a0, d0, wr1, a1, d1, $sformatf("random pair %0d", done), rd0, rd1);
        done += 2;
      end else begin
        checked_access(kind, wr0, a0, d0, $sformatf("random access %0d", done));
        done++;
      end
    end
  endtask

  initial begin
    void'($urandom(32'hcec2_2327));
    clock        = 1'b0;
    rst_n        = 1'b0;
    port_0_req   = 1'b0;
    port_0_write = 1'b0;
    port_0_addr  = '0;
    port_0_wdata = '0;
    port_1_req   = 1'b0;
    port_1_write = 1'b0;
    port_1_addr  = '0;
    port_1_wdata = '0;
    // Four reset edges
    repeat (4) @(negedge clock);
    rst_n = 1'b1;
    reset_and_round_trip();
    cross_port_visibility();
    read_during_write();
    write_collision();
    back_pressure();
    random_traffic();
    if (check_count > 0) begin
      $display("** PASS **");
    end else begin
      $display("No checks ran");
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+verilog
verilog/shared_mem_pkg.sv
verilog/true_dual_port_ram.sv
verilog/port_sequencer.sv
verilog/shared_mem_top.sv
test/port_sequencer_asserts.sv
test/shared_mem_tb.sv

/* Makefile */
# Verilator build and run of the shared memory testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module shared_mem_tb -f filelist.f
	@out="$$(./obj_dir/Vshared_mem_tb)"; echo "$$out"; \
	  echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
